/* hdl/bob_cfg.svh */
// Sizing and latency macros for the retirement buffer, included by the package and the RTL.
`ifndef BOB_CFG_SVH
`define BOB_CFG_SVH

// number of buffer slots, a power of two so tags wrap on their own.
`define BOB_COUNT 8

// slot index width.
`define BOB_ADDR_WIDTH 3

// result word width.
`define BOB_DATA_WIDTH 16

// long lane depth in cycles.
`define BOB_LONG_LAT 3

// operand field widths of the instruction word.
`define BOB_OPND_WIDTH 7
`define BOB_IMM_WIDTH 14

`endif

/* hdl/bob_pkg.sv */
// Shared opcode, instruction and word types, imported by the interfaces and RTL modules.
`include "bob_cfg.svh"
`default_nettype none

package bob_pkg;

  typedef logic [`BOB_ADDR_WIDTH-1:0] bob_tag_t; // slot index.
  typedef logic [`BOB_DATA_WIDTH-1:0] bob_word_t; // result word.

  typedef enum logic [1:0] {
    OP_ADD = 2'd0, // a + b, short lane.
    OP_XOR = 2'd1, // a ^ b, short lane.
    OP_LDI = 2'd2, // sign-extended imm, short lane.
    OP_MUL = 2'd3  // a * b, long lane.
  } bob_op_e;

  typedef struct packed {
    bob_op_e                    op;
    logic [`BOB_OPND_WIDTH-1:0] a;
    logic [`BOB_OPND_WIDTH-1:0] b;
  } insn_reg_t;

  typedef struct packed {
    bob_op_e                   op;
    logic [`BOB_IMM_WIDTH-1:0] imm;
  } insn_imm_t;

  // both views put op in the top two bits.
  typedef union packed {
    insn_reg_t r;
    insn_imm_t i;
  } insn_u;

endpackage

`default_nettype wire

/* hdl/bob_if.sv */
// Allocation, dispatch and writeback buses between the buffer's internal blocks.
`include "bob_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

interface bob_alloc_if import bob_pkg::*; ();
  logic     alloc; // one slot per high cycle.
  logic     pop;
  bob_tag_t tail;
  logic     full;
  logic     empty;

  modport decode (output alloc, input tail, input full);
  modport buffer (input alloc, input pop, output tail, output full, output empty);
  modport retire (output pop, input empty);
endinterface

interface bob_dispatch_if import bob_pkg::*; ();
  logic                       valid;
  bob_op_e                    op;
  logic [`BOB_OPND_WIDTH-1:0] a;
  logic [`BOB_OPND_WIDTH-1:0] b;
  logic [`BOB_IMM_WIDTH-1:0]  imm;
  bob_tag_t                   tag;

  modport decode (output valid, output op, output a, output b, output imm, output tag);
  modport execute (input valid, input op, input a, input b, input imm, input tag);
endinterface

interface bob_wb_if import bob_pkg::*; ();
  logic      short_wen;
  bob_tag_t  short_tag;
  bob_word_t short_data;
  logic      long_wen;
  bob_tag_t  long_tag;
  bob_word_t long_data;

  modport execute (output short_wen, output short_tag, output short_data,
                   output long_wen, output long_tag, output long_data);
  modport buffer (input short_wen, input short_tag, input short_data,
                  input long_wen, input long_tag, input long_data);
endinterface

`default_nettype wire

/* hdl/bob_decode.sv */
// Issue stage that allocates a buffer slot for each accepted word and registers the dispatch.
`include "bob_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module bob_decode
  import bob_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  logic           issue_valid,
  input  insn_u          issue_word,
  bob_alloc_if.decode    alloc,
  bob_dispatch_if.decode disp
);

  logic accept;
  logic use_imm;

  assign accept = issue_valid && !alloc.full; // held words are not taken.
  assign alloc.alloc = accept;

  // immediate form only for OP_LDI.
  assign use_imm = (issue_word.i.op == OP_LDI);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      disp.valid <= 1'b0;
    end
    else
    begin
      disp.valid <= accept;
    end
  end

  // payload registers, qualified by disp.valid downstream.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      disp.op  <= issue_word.r.op;
      disp.tag <= alloc.tail; // slot allocated on this same edge.
      if (use_imm)
      begin
        disp.a   <= '0;
        disp.b   <= '0;
        disp.imm <= issue_word.i.imm;
      end
      else
      begin
        disp.a   <= issue_word.r.a;
        disp.b   <= issue_word.r.b;
        disp.imm <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/bob_execute.sv */
// Short and long execution lanes that write their results back into the buffer by tag.
`include "bob_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module bob_execute
  import bob_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  bob_dispatch_if.execute disp,
  bob_wb_if.execute       wb
);

  localparam int PAD_OPND = `BOB_DATA_WIDTH - `BOB_OPND_WIDTH;
  localparam int PAD_IMM  = `BOB_DATA_WIDTH - `BOB_IMM_WIDTH;

  bob_word_t                a_ext;
  bob_word_t                b_ext;
  bob_word_t                imm_ext;
  bob_word_t                short_res;
  logic [`BOB_LONG_LAT-1:0] mul_valid;
  bob_tag_t                 mul_tag [`BOB_LONG_LAT];
  bob_word_t                mul_prod [`BOB_LONG_LAT];

  assign a_ext   = {{PAD_OPND{1'b0}}, disp.a}; // operands are unsigned.
  assign b_ext   = {{PAD_OPND{1'b0}}, disp.b};
  assign imm_ext = {{PAD_IMM{disp.imm[`BOB_IMM_WIDTH-1]}}, disp.imm};

  always_comb
  begin
    case (disp.op)
      OP_ADD:  short_res = a_ext + b_ext;
      OP_XOR:  short_res = a_ext ^ b_ext;
      default: short_res = imm_ext; // OP_MUL never writes here.
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb.short_wen <= 1'b0;
      mul_valid    <= '0;
    end
    else
    begin
      wb.short_wen <= disp.valid && (disp.op != OP_MUL);
      mul_valid    <= {mul_valid[`BOB_LONG_LAT-2:0], disp.valid && (disp.op == OP_MUL)};
    end
  end

  // up to BOB_LONG_LAT multiplies in flight, one per stage.
  always_ff @(posedge clk)
  begin
    wb.short_tag  <= disp.tag;
    wb.short_data <= short_res;
    mul_tag[0]    <= disp.tag;
    mul_prod[0]   <= a_ext * b_ext; // 7x7 bits fits the word.
    for (int i = 1; i < `BOB_LONG_LAT; i++)
    begin
      mul_tag[i]  <= mul_tag[i-1];
      mul_prod[i] <= mul_prod[i-1];
    end
  end

  assign wb.long_wen  = mul_valid[`BOB_LONG_LAT-1];
  assign wb.long_tag  = mul_tag[`BOB_LONG_LAT-1];
  assign wb.long_data = mul_prod[`BOB_LONG_LAT-1];

endmodule

`default_nettype wire

/* hdl/bob_index.sv */
// Result and ready storage of the buffer with a registered read address, plus tail and count.
`include "bob_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module bob_index
  import bob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  bob_alloc_if.buffer alloc,
  bob_wb_if.buffer    wb,
  input  bob_tag_t    read_addr,
  output bob_word_t   read_data,
  output logic        read_ready
);

  bob_word_t                data_ram [`BOB_COUNT];
  logic                     ready_ram [`BOB_COUNT];
  bob_tag_t                 read_addr_reg;
  bob_tag_t                 tail;
  logic [`BOB_ADDR_WIDTH:0] count; // one extra bit to hold a full buffer.

  assign read_data  = data_ram[read_addr_reg];
  assign read_ready = ready_ram[read_addr_reg];

  always_ff @(posedge clk)
  begin
    if (rst) read_addr_reg <= '0;
    else read_addr_reg <= read_addr;
  end

  // two lane write ports, tags never collide.
  always_ff @(posedge clk)
  begin
    if (wb.short_wen) data_ram[wb.short_tag] <= wb.short_data;
    if (wb.long_wen) data_ram[wb.long_tag] <= wb.long_data;
  end

  // allocation clears, each lane sets.
  always_ff @(posedge clk)
  begin
    if (alloc.alloc) ready_ram[tail] <= 1'b0;
    if (wb.short_wen) ready_ram[wb.short_tag] <= 1'b1;
    if (wb.long_wen) ready_ram[wb.long_tag] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      if (alloc.alloc) tail <= tail + 1'b1; // wraps at BOB_COUNT.
      case ({alloc.alloc, alloc.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign alloc.tail  = tail;
  assign alloc.full  = (count == (`BOB_ADDR_WIDTH+1)'(`BOB_COUNT));
  assign alloc.empty = (count == '0);

endmodule

`default_nettype wire

/* hdl/bob_retire.sv */
// Retire stage that walks the head pointer and emits finished results in program order.
`timescale 1ns/1ps
`default_nettype none

module bob_retire
  import bob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  bob_alloc_if.retire alloc,
  output bob_tag_t    read_addr,
  input  bob_word_t   read_data,
  input  logic        read_ready,
  output logic        retire_valid,
  output bob_tag_t    retire_tag,
  output bob_word_t   retire_data
);

  bob_tag_t head;
  bob_tag_t head_next;
  logic     pop;

  // buffer's registered read address tracks head.
  assign pop       = !alloc.empty && read_ready;
  assign head_next = head + 1'b1;
  assign read_addr = pop ? head_next : head; // next head on the popping cycle.
  assign alloc.pop = pop;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      head         <= '0;
      retire_valid <= 1'b0;
    end
    else
    begin
      head         <= read_addr;
      retire_valid <= pop;
    end
  end

  // retired payload, valid with retire_valid.
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      retire_tag  <= head;
      retire_data <= read_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/bob_top.sv */
// Top level of the retirement buffer, joining decode, execute, storage and retire.
`timescale 1ns/1ps
`default_nettype none

module bob_top
  import bob_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_valid,
  input  insn_u     issue_word,
  output logic      issue_ready,
  output logic      retire_valid,
  output bob_tag_t  retire_tag,
  output bob_word_t retire_data
);

  bob_tag_t  read_addr;
  bob_word_t read_data;
  logic      read_ready;

  bob_alloc_if    alloc_bus ();
  bob_dispatch_if disp_bus ();
  bob_wb_if       wb_bus ();

  assign issue_ready = !alloc_bus.full; // stalls only on a full buffer.

  bob_decode decode0 (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_word  (issue_word),
    .alloc       (alloc_bus.decode),
    .disp        (disp_bus.decode)
  );

  bob_execute execute0 (
    .clk  (clk),
    .rst  (rst),
    .disp (disp_bus.execute),
    .wb   (wb_bus.execute)
  );

  bob_index index0 (
    .clk        (clk),
    .rst        (rst),
    .alloc      (alloc_bus.buffer),
    .wb         (wb_bus.buffer),
    .read_addr  (read_addr),
    .read_data  (read_data),
    .read_ready (read_ready)
  );

  bob_retire retire0 (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc_bus.retire),
    .read_addr    (read_addr),
    .read_data    (read_data),
    .read_ready   (read_ready),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

/* testbench/bob_sva.sv */
// Concurrent assertions on buffer occupancy and write ports, bound into bob_top.
`include "bob_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module bob_sva
  import bob_pkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input logic [`BOB_ADDR_WIDTH:0] count,
  input logic                     alloc,
  input logic                     pop,
  input logic                     full,
  input logic                     empty,
  input bob_tag_t                 head,
  input bob_tag_t                 tail,
  input logic                     short_wen,
  input logic                     long_wen,
  input bob_tag_t                 short_tag,
  input bob_tag_t                 long_tag
);

  count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= (`BOB_ADDR_WIDTH+1)'(`BOB_COUNT))
    else $error("buffer count above slot total");

  // a new slot never lands on the oldest one still waiting.
  no_alloc_full: assert property (@(posedge clk) disable iff (rst)
    (alloc && !empty) |-> (tail != head))
    else $error("slot allocated while buffer full");

  // the popped head slot is always an occupied one.
  no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> ((head != tail) || full))
    else $error("pop while buffer empty");

  // both lanes may write together, never the same slot.
  distinct_tags: assert property (@(posedge clk) disable iff (rst)
    (short_wen && long_wen) |-> (short_tag != long_tag))
    else $error("short and long lanes wrote the same tag");

endmodule

bind bob_top bob_sva sva0 (
  .clk       (clk),
  .rst       (rst),
  .count     (index0.count),
  .alloc     (alloc_bus.alloc),
  .pop       (alloc_bus.pop),
  .full      (alloc_bus.full),
  .empty     (alloc_bus.empty),
  .head      (retire0.head),
  .tail      (alloc_bus.tail),
  .short_wen (wb_bus.short_wen),
  .long_wen  (wb_bus.long_wen),
  .short_tag (wb_bus.short_tag),
  .long_tag  (wb_bus.long_tag)
);

`default_nettype wire

/* testbench/bob_tb.sv */
// Random-stimulus testbench for bob_top that checks in-order retirement against a queue model.
`include "bob_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module bob_tb
  import bob_pkg::*;
;

  localparam int NUM_ISSUES = 400;
  localparam int MAX_CYCLES = 3000; // about 800 cycles at half issue rate, plus stalls and drain.
  localparam logic [31:0] SEED = 32'hb9507535;

  logic      clk;
  logic      rst;
  logic      issue_valid;
  insn_u     issue_word;
  logic      issue_ready;
  logic      retire_valid;
  bob_tag_t  retire_tag;
  bob_word_t retire_data;

  logic [31:0] lfsr;
  bob_word_t   model_q [$];
  bob_tag_t    tag_q [$];
  int          issued;
  int          retired;
  int          cycles;

  bob_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_word   (issue_word),
    .issue_ready  (issue_ready),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .retire_data  (retire_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input bob_word_t got, input bob_word_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_tag(input string name, input bob_tag_t got, input bob_tag_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // galois form, taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    else
      return s >> 1;
  endfunction

  // one lfsr step per bit taken.
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // opcode rules, operands zero-extended.
  function automatic bob_word_t expected_result(input insn_u w);
    bob_word_t a;
    bob_word_t b;
    a = {9'd0, w.r.a};
    b = {9'd0, w.r.b};
    case (w.r.op)
      OP_ADD:  return a + b;
      OP_XOR:  return a ^ b;
      OP_LDI:  return {{2{w.i.imm[13]}}, w.i.imm};
      default: return a * b;
    endcase
  endfunction

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
      abort_run("timeout waiting for all issued words to retire");
  end

  // retire monitor, sees pre-edge values.
  always @(posedge clk)
  begin
    if (!rst && retire_valid)
    begin
      if (model_q.size() == 0)
        abort_run("retire pulse with no outstanding issue in the model");
      check_tag("retire_tag", retire_tag, tag_q.pop_front());
      check_word("retire_data", retire_data, model_q.pop_front());
      retired++;
    end
  end

  initial
  begin
    logic        vbit;
    logic        dense;
    logic [15:0] draw;
    rst = 1'b1;
    issue_valid = 1'b0;
    issue_word = '0;
    lfsr = SEED;
    issued = 0;
    retired = 0;
    cycles = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // idle after reset.
    repeat (4)
    begin
      @(posedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("issue_ready", issue_ready, 1'b1);
    end
    while (issued < NUM_ISSUES)
    begin
      @(posedge clk);
      if (issue_valid && issue_ready)
      begin
        model_q.push_back(expected_result(issue_word));
        tag_q.push_back(bob_tag_t'(issued % `BOB_COUNT));
        issued++;
      end
      if (issued == NUM_ISSUES)
        issue_valid <= 1'b0;
      else if (!(issue_valid && !issue_ready)) // a refused word is held.
      begin
        // back-to-back windows keep several multiplies in flight.
        dense = (issued >= 100 && issued < 200) || (issued >= 300 && issued < 350);
        draw = take_bits(1);
        vbit = draw[0];
        issue_valid <= vbit | dense;
        issue_word  <= insn_u'(take_bits(16));
      end
    end
    while (retired < NUM_ISSUES)
      @(posedge clk);
    repeat (10) @(posedge clk); // catch any extra retire.
    if (model_q.size() != 0 || retired != NUM_ISSUES)
      abort_run("results lost or duplicated at end of run");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bob_top.f */
+incdir+hdl
hdl/bob_pkg.sv
hdl/bob_if.sv
hdl/bob_decode.sv
hdl/bob_execute.sv
hdl/bob_index.sv
hdl/bob_retire.sv
hdl/bob_top.sv
testbench/bob_sva.sv
testbench/bob_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module bob_tb -f bob_top.f -o bob_sim
status=0
./obj_dir/bob_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Test completed successfully" sim.log; then
  echo "simulation did not finish cleanly"
  exit 1
fi
exit 0
